// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module core_tb -f flist.f
	./obj_dir/Vcore_tb

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+include
src/core_pkg.sv
src/retire_if.sv
src/fetch.sv
src/decode.sv
src/pipe_stage.sv
src/reg_file.sv
src/exec.sv
src/core_top.sv
verification/core_tb.sv

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// machine widths
`define CORE_XLEN       32
`define CORE_REG_ADDR_W 5
`define CORE_STRB_W     4

// first instruction fetched after reset
`define CORE_START_ADDR 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP_INST   32'h0000_0013

`endif

// ==== src/core_pkg.sv ====
`default_nettype none
`include "core_consts.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]       word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CORE_STRB_W-1:0]     strb_t;

    // opcode groups the core keeps, anything else is grp_other
    typedef enum logic [2:0] {
        grp_other, grp_op, grp_op_imm, grp_lui, grp_auipc, grp_branch, grp_jal, grp_store
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetched_t;

    typedef struct packed {
        word_t     pc;
        opcode_e   group;
        alu_op_e   alu_op;
        logic [2:0] br_cond;
        logic [1:0] st_size;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        // operand b is the immediate
        logic      imm_sel;
        // operand a is the pc
        logic      pc_sel;
    } decoded_t;

endpackage

`default_nettype wire

// ==== src/core_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top #(
    parameter core_pkg::word_t start_addr = `CORE_START_ADDR
) (
    input  wire                  clk,
    input  wire                  rst,
    output logic                 inst_rden,
    output core_pkg::word_t      inst_riaddr,
    input  wire core_pkg::word_t inst_roaddr,
    input  wire                  inst_rvalid,
    input  wire core_pkg::word_t inst_rdata,
    output logic                 data_wren,
    output core_pkg::strb_t      data_wstrb,
    output core_pkg::word_t      data_waddr,
    output core_pkg::word_t      data_wdata,
    input  wire                  mem_wait
);

    core_pkg::fetched_t  fetched, fetch_q;
    core_pkg::decoded_t  decoded, decode_q;
    core_pkg::reg_addr_t rs1, rs2;
    core_pkg::word_t     rs1_data, rs2_data;
    logic                fetched_valid, fetch_q_valid, decode_q_valid;
    logic                flush;

    retire_if rt ();

    // a retiring jump throws away everything younger
    assign flush = rt.jmp_do && !mem_wait;

    fetch #(
        .start_addr (start_addr)
    ) fetch_i (
        .clk           (clk),
        .rst           (rst),
        .mem_wait      (mem_wait),
        .flush         (flush),
        .rt            (rt),
        .inst_rden     (inst_rden),
        .inst_riaddr   (inst_riaddr),
        .inst_roaddr   (inst_roaddr),
        .inst_rvalid   (inst_rvalid),
        .inst_rdata    (inst_rdata),
        .fetched       (fetched),
        .fetched_valid (fetched_valid)
    );

    pipe_stage #(
        .payload_t (core_pkg::fetched_t)
    ) fetch_stage (
        .clk       (clk),
        .rst       (rst),
        .hold      (mem_wait),
        .flush     (flush),
        .in_valid  (fetched_valid),
        .in_data   (fetched),
        .out_valid (fetch_q_valid),
        .out_data  (fetch_q)
    );

    decode decode_i (
        .fetched (fetch_q),
        .decoded (decoded)
    );

    pipe_stage #(
        .payload_t (core_pkg::decoded_t)
    ) decode_stage (
        .clk       (clk),
        .rst       (rst),
        .hold      (mem_wait),
        .flush     (flush),
        .in_valid  (fetch_q_valid),
        .in_data   (decoded),
        .out_valid (decode_q_valid),
        .out_data  (decode_q)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .mem_wait (mem_wait),
        .wb       (rt),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec exec_i (
        .clk      (clk),
        .rst      (rst),
        .mem_wait (mem_wait),
        .flush    (flush),
        .in_valid (decode_q_valid),
        .decoded  (decode_q),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rt       (rt)
    );

    // store port shows the retire register as is
    assign data_wren  = rt.mem_w_en;
    assign data_wstrb = rt.mem_w_strb;
    assign data_waddr = rt.mem_w_addr;
    assign data_wdata = rt.mem_w_data;

endmodule

`default_nettype wire

// ==== src/decode.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module decode (
    input  wire core_pkg::fetched_t fetched,
    output core_pkg::decoded_t      decoded
);

    core_pkg::word_t   inst;
    core_pkg::word_t   fields;
    core_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    core_pkg::opcode_e group;
    core_pkg::alu_op_e alu;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              f7_zero, f7_alt;

    assign inst    = fetched.inst;
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = funct7 == 7'h00;
    assign f7_alt  = funct7 == 7'h20;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        group = core_pkg::grp_other;
        case (inst[6:0])
            7'b0110011: begin
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))
                    group = core_pkg::grp_op;
            end
            7'b0010011: begin
                // shifts by immediate still carry a funct7
                if ((funct3 != 3'b001 && funct3 != 3'b101) || f7_zero ||
                    (f7_alt && funct3 == 3'b101))
                    group = core_pkg::grp_op_imm;
            end
            7'b0110111: group = core_pkg::grp_lui;
            7'b0010111: group = core_pkg::grp_auipc;
            7'b1100011: begin
                if (funct3[2:1] != 2'b01)
                    group = core_pkg::grp_branch;
            end
            7'b1101111: group = core_pkg::grp_jal;
            7'b0100011: begin
                if (!funct3[2] && funct3[1:0] != 2'b11)
                    group = core_pkg::grp_store;
            end
            default: group = core_pkg::grp_other;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu = (group == core_pkg::grp_op && funct7[5]) ?
                           core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  alu = core_pkg::alu_sll;
            3'b010:  alu = core_pkg::alu_slt;
            3'b011:  alu = core_pkg::alu_sltu;
            3'b100:  alu = core_pkg::alu_xor;
            3'b101:  alu = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  alu = core_pkg::alu_or;
            default: alu = core_pkg::alu_and;
        endcase
        // everything else only needs an adder
        if (group != core_pkg::grp_op && group != core_pkg::grp_op_imm)
            alu = core_pkg::alu_add;
    end

    // dropped encodings take the register fields of a no-op
    assign fields = (group == core_pkg::grp_other) ? `CORE_NOP_INST : inst;

    always_comb begin
        decoded.pc      = fetched.pc;
        decoded.group   = group;
        decoded.alu_op  = alu;
        decoded.br_cond = funct3;
        decoded.st_size = funct3[1:0];
        decoded.rd      = fields[11:7];
        decoded.rs1     = fields[19:15];
        decoded.rs2     = fields[24:20];
        decoded.imm     = imm_i;
        decoded.imm_sel = 1'b1;
        decoded.pc_sel  = 1'b0;
        case (group)
            core_pkg::grp_op: decoded.imm_sel = 1'b0;
            core_pkg::grp_lui: begin
                decoded.rs1 = '0;
                decoded.imm = imm_u;
            end
            core_pkg::grp_auipc: begin
                decoded.rs1    = '0;
                decoded.imm    = imm_u;
                decoded.pc_sel = 1'b1;
            end
            core_pkg::grp_branch: begin
                decoded.rd      = '0;
                decoded.imm     = imm_b;
                decoded.imm_sel = 1'b0;
            end
            core_pkg::grp_jal: begin
                decoded.rs1 = '0;
                decoded.imm = imm_j;
            end
            core_pkg::grp_store: begin
                decoded.rd  = '0;
                decoded.imm = imm_s;
            end
            default: decoded.imm_sel = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/exec.sv ====
`default_nettype none
`timescale 1ns/1ps

module exec (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      mem_wait,
    input  wire                      flush,
    input  wire                      in_valid,
    input  wire core_pkg::decoded_t  decoded,
    input  wire core_pkg::word_t     rs1_data,
    input  wire core_pkg::word_t     rs2_data,
    output core_pkg::reg_addr_t      rs1,
    output core_pkg::reg_addr_t      rs2,
    retire_if.source                 rt
);

    core_pkg::word_t op_a, op_b, alu_res, link_pc, br_target, st_data;
    core_pkg::strb_t st_strb;
    logic            cond, taken, is_store;

    assign rs1 = decoded.rs1;
    assign rs2 = decoded.rs2;

    assign op_a = decoded.pc_sel ? decoded.pc : rs1_data;
    assign op_b = decoded.imm_sel ? decoded.imm : rs2_data;

    always_comb begin
        case (decoded.alu_op)
            core_pkg::alu_sub:  alu_res = op_a - op_b;
            core_pkg::alu_and:  alu_res = op_a & op_b;
            core_pkg::alu_or:   alu_res = op_a | op_b;
            core_pkg::alu_xor:  alu_res = op_a ^ op_b;
            core_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
            core_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
            core_pkg::alu_sra:  alu_res = core_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            core_pkg::alu_slt:  alu_res = core_pkg::word_t'($signed(op_a) < $signed(op_b));
            core_pkg::alu_sltu: alu_res = core_pkg::word_t'(op_a < op_b);
            default:            alu_res = op_a + op_b;
        endcase
    end

    // funct3 of the branch
    always_comb begin
        case (decoded.br_cond)
            3'b000:  cond = rs1_data == rs2_data;
            3'b001:  cond = rs1_data != rs2_data;
            3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  cond = rs1_data < rs2_data;
            default: cond = rs1_data >= rs2_data;
        endcase
    end

    assign taken = (decoded.group == core_pkg::grp_branch && cond) ||
                   decoded.group == core_pkg::grp_jal;
    assign br_target = decoded.pc + decoded.imm;
    assign link_pc   = decoded.pc + core_pkg::word_t'(4);
    assign is_store  = decoded.group == core_pkg::grp_store;

    // narrow stores are replicated so the addressed lane always has the data
    always_comb begin
        case (decoded.st_size)
            2'b00: begin
                st_data = {4{rs2_data[7:0]}};
                st_strb = 4'b0001 << alu_res[1:0];
            end
            2'b01: begin
                st_data = {2{rs2_data[15:0]}};
                st_strb = 4'b0011 << {alu_res[1], 1'b0};
            end
            default: begin
                st_data = rs2_data;
                st_strb = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rt.reg_w_en   <= 1'b0;
            rt.mem_w_en   <= 1'b0;
            rt.mem_w_strb <= '0;
            rt.jmp_do     <= 1'b0;
        end else if (!mem_wait) begin
            if (flush || !in_valid) begin
                rt.reg_w_en   <= 1'b0;
                rt.mem_w_en   <= 1'b0;
                rt.mem_w_strb <= '0;
                rt.jmp_do     <= 1'b0;
            end else begin
                // decode leaves rd at zero for anything that writes no register
                rt.reg_w_en   <= decoded.rd != '0;
                rt.mem_w_en   <= is_store;
                rt.mem_w_strb <= is_store ? st_strb : '0;
                rt.jmp_do     <= taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            rt.reg_w_rd   <= decoded.rd;
            rt.reg_w_data <= (decoded.group == core_pkg::grp_jal) ? link_pc : alu_res;
            rt.mem_w_addr <= alu_res;
            rt.mem_w_data <= st_data;
            rt.jmp_pc     <= br_target;
        end
    end

    a_store_strb: assert property (@(posedge clk) disable iff (rst)
        rt.mem_w_en |-> rt.mem_w_strb != '0)
        else $error("store retired with no strobes");

endmodule

`default_nettype wire

// ==== src/fetch.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch #(
    parameter core_pkg::word_t start_addr = `CORE_START_ADDR
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    mem_wait,
    input  wire                    flush,
    retire_if.redirect             rt,
    output logic                   inst_rden,
    output core_pkg::word_t        inst_riaddr,
    input  wire core_pkg::word_t   inst_roaddr,
    input  wire                    inst_rvalid,
    input  wire core_pkg::word_t   inst_rdata,
    output core_pkg::fetched_t     fetched,
    output logic                   fetched_valid
);

    localparam core_pkg::word_t inst_bytes = `CORE_XLEN / 8;

    core_pkg::word_t pc;
    logic            accept;

    // stale answers after a flush carry the old address and fall out here
    assign accept = inst_rden && inst_rvalid && inst_roaddr == pc && !mem_wait && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= start_addr;
            inst_rden <= 1'b0;
        end else begin
            inst_rden <= 1'b1;
            if (flush) begin
                pc <= rt.jmp_pc;
            end else if (accept) begin
                pc <= pc + inst_bytes;
            end
        end
    end

    assign inst_riaddr   = pc;
    assign fetched.pc    = pc;
    assign fetched.inst  = inst_rdata;
    assign fetched_valid = accept;

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_rden |-> inst_riaddr[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", inst_riaddr);

endmodule

`default_nettype wire

// ==== src/pipe_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           hold,
    input  wire           flush,
    input  wire           in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush |=> !out_valid)
        else $error("stage still valid after flush");

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      mem_wait,
    retire_if.writeback              wb,
    input  wire core_pkg::reg_addr_t rs1,
    input  wire core_pkg::reg_addr_t rs2,
    output core_pkg::word_t          rs1_data,
    output core_pkg::word_t          rs2_data
);

    core_pkg::word_t regs [1:31];
    logic            wr_en;

    // written on the edge that replaces the retire register
    assign wr_en = wb.reg_w_en && !mem_wait && wb.reg_w_rd != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.reg_w_rd] <= wb.reg_w_data;
        end
    end

    function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        // value still waiting in the retire register
        if (wb.reg_w_en && wb.reg_w_rd == addr)
            return wb.reg_w_data;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// ==== src/retire_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface retire_if;

    logic                reg_w_en;
    core_pkg::reg_addr_t reg_w_rd;
    core_pkg::word_t     reg_w_data;
    logic                mem_w_en;
    core_pkg::strb_t     mem_w_strb;
    core_pkg::word_t     mem_w_addr;
    core_pkg::word_t     mem_w_data;
    logic                jmp_do;
    core_pkg::word_t     jmp_pc;

    modport source (
        output reg_w_en, reg_w_rd, reg_w_data,
        output mem_w_en, mem_w_strb, mem_w_addr, mem_w_data,
        output jmp_do, jmp_pc
    );

    modport writeback (input reg_w_en, reg_w_rd, reg_w_data);

    modport redirect (input jmp_do, jmp_pc);

endinterface

`default_nettype wire

// ==== verification/core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;

    localparam core_pkg::word_t start_addr = `CORE_START_ADDR;
    localparam int prog_words = 200;
    localparam int final_idx = prog_words - 1;
    localparam core_pkg::word_t final_addr = start_addr + core_pkg::word_t'(final_idx * 4);
    localparam int clk_period = 8;
    // three cycles a word, four times over for stalls
    localparam int timeout_ns = prog_words * 3 * clk_period * 4;

    logic            clk;
    logic            rst;
    logic            inst_rden;
    core_pkg::word_t inst_riaddr;
    core_pkg::word_t inst_roaddr;
    logic            inst_rvalid;
    core_pkg::word_t inst_rdata;
    logic            data_wren;
    core_pkg::strb_t data_wstrb;
    core_pkg::word_t data_waddr;
    core_pkg::word_t data_wdata;
    logic            mem_wait;

    core_pkg::word_t prog [0:prog_words-1];
    core_pkg::word_t exp_addr [$];
    core_pkg::strb_t exp_strb [$];
    core_pkg::word_t exp_data [$];
    logic [31:0]     rng;
    core_pkg::word_t last_fetch;
    logic            reached_end;
    int              stores_seen;

    core_top #(
        .start_addr (start_addr)
    ) core_top_i (
        .clk         (clk),
        .rst         (rst),
        .inst_rden   (inst_rden),
        .inst_riaddr (inst_riaddr),
        .inst_roaddr (inst_roaddr),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .data_wren   (data_wren),
        .data_wstrb  (data_wstrb),
        .data_waddr  (data_waddr),
        .data_wdata  (data_wdata),
        .mem_wait    (mem_wait)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic core_pkg::word_t r_type(input logic [6:0] f7,
        input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1,
        input logic [2:0] f3, input core_pkg::reg_addr_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word_t i_type(input logic [11:0] imm,
        input core_pkg::reg_addr_t rs1, input logic [2:0] f3,
        input core_pkg::reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word_t s_type(input logic [11:0] imm,
        input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t b_type(input logic [12:0] imm,
        input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t u_type(input logic [19:0] imm,
        input core_pkg::reg_addr_t rd, input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic core_pkg::word_t j_type(input logic [20:0] imm,
        input core_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // RV32I integer semantics, alt is instruction bit 30
    function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
        input core_pkg::word_t a, input core_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input core_pkg::word_t a,
        input core_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic core_pkg::word_t fetch_word(input core_pkg::word_t addr);
        core_pkg::word_t offset;
        offset = addr - start_addr;
        if (offset[1:0] == 2'b00 && (offset >> 2) < core_pkg::word_t'(prog_words)) begin
            return prog[offset[9:2]];
        end
        return `CORE_NOP_INST;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic addr_compare(input string sig, input core_pkg::word_t got,
        input core_pkg::word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", sig, got, exp));
        end
    endtask

    task automatic strb_compare(input core_pkg::strb_t got, input core_pkg::strb_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch data_wstrb: got %h, expected %h", got, exp));
        end
    endtask

    // only the strobed lanes carry data
    task automatic data_compare(input core_pkg::word_t got, input core_pkg::word_t exp,
        input core_pkg::strb_t lanes);
        core_pkg::word_t mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        if ((got & mask) !== (exp & mask)) begin
            stop_with_error($sformatf("mismatch data_wdata: got %h, expected %h, strobes %h",
                got, exp, lanes));
        end
    endtask

    task automatic build_program();
        logic [31:0]         r;
        logic [31:0]         s;
        logic [3:0]          kind;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic [11:0]         imm;
        core_pkg::reg_addr_t rd, rs1, rs2;
        int                  span;
        logic                store_next;
        int                  since_store;
        store_next = 1'b0;
        since_store = 0;
        for (int i = 0; i < final_idx; i++) begin
            rng = xorshift(rng);
            r = rng;
            rng = xorshift(rng);
            s = rng;
            kind = r[3:0];
            // few registers so that neighbours depend on each other
            rd = {2'b00, r[6:4]};
            rs1 = {2'b00, r[9:7]};
            rs2 = {2'b00, r[12:10]};
            f3 = r[15:13];
            span = 2 + int'(s[2:0]);
            if (store_next || since_store >= 4) begin
                kind = 4'd15;
            end
            // a jump needs room to skip its store slot
            if (kind inside {4'd10, 4'd11} && i + 2 > final_idx) begin
                kind = 4'd0;
            end
            if (i + span > final_idx) begin
                span = final_idx - i;
            end
            store_next = 1'b0;
            since_store++;
            case (kind)
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                    imm = s[31:20];
                    if (f3 == 3'b001) begin
                        imm = {7'h00, s[24:20]};
                    end
                    if (f3 == 3'b101) begin
                        imm = {r[16] ? 7'h20 : 7'h00, s[24:20]};
                    end
                    prog[8'(i)] = i_type(imm, rs1, f3, rd, 7'b0010011);
                end
                4'd5, 4'd6, 4'd7: begin
                    f7 = (r[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                    prog[8'(i)] = r_type(f7, rs2, rs1, f3, rd, 7'b0110011);
                end
                4'd8: prog[8'(i)] = u_type(s[31:12], rd, 7'b0110111);
                4'd9: prog[8'(i)] = u_type(s[31:12], rd, 7'b0010111);
                4'd10: begin
                    // funct3 010 and 011 are not branches
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;
                    end
                    prog[8'(i)] = b_type(13'(span * 4), rs2, rs1, f3);
                    store_next = 1'b1;
                end
                4'd11: begin
                    prog[8'(i)] = j_type(21'(span * 4), rd);
                    store_next = 1'b1;
                end
                4'd12: begin
                    case (r[17:16])
                        2'b00:   prog[8'(i)] = i_type(s[31:20], rs1, 3'b010, rd, 7'b0000011);
                        2'b01:   prog[8'(i)] = i_type(s[31:20], rs1, 3'b001, rd, 7'b1110011);
                        default: prog[8'(i)] = r_type(7'h01, rs2, rs1, f3, rd, 7'b0110011);
                    endcase
                end
                default: begin
                    f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
                    prog[8'(i)] = s_type(s[31:20], rs2, rs1, f3);
                    since_store = 0;
                end
            endcase
        end
        prog[8'(final_idx)] = j_type(21'd0, 5'd0);
    endtask

    task automatic queue_store(input core_pkg::word_t addr, input logic [2:0] f3,
        input core_pkg::word_t value);
        core_pkg::strb_t strb;
        core_pkg::word_t lanes;
        case (f3[1:0])
            2'b00: begin
                strb = 4'b0001 << addr[1:0];
                lanes = core_pkg::word_t'(value[7:0]) << {addr[1:0], 3'b000};
            end
            2'b01: begin
                // a half sits in the lane picked by bit 1
                strb = 4'b0011 << {addr[1], 1'b0};
                lanes = core_pkg::word_t'(value[15:0]) << {addr[1], 4'b0000};
            end
            default: begin
                strb = 4'b1111;
                lanes = value;
            end
        endcase
        exp_addr.push_back(addr);
        exp_strb.push_back(strb);
        exp_data.push_back(lanes);
    endtask

    task automatic run_model();
        core_pkg::word_t     x [0:31];
        core_pkg::word_t     pc, next_pc, inst, a, b, res, off;
        core_pkg::reg_addr_t rd;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic                wr;
        int                  steps;
        for (int k = 0; k < 32; k++) begin
            x[5'(k)] = '0;
        end
        pc = start_addr;
        steps = 0;
        while (pc != final_addr) begin
            if (steps > prog_words) begin
                stop_with_error("reference model ran past the end of the program");
            end
            off = pc - start_addr;
            inst = prog[off[9:2]];
            rd = inst[11:7];
            f3 = inst[14:12];
            f7 = inst[31:25];
            a = x[inst[19:15]];
            b = x[inst[24:20]];
            res = '0;
            wr = 1'b0;
            next_pc = pc + 32'd4;
            case (inst[6:0])
                7'b0010011: begin
                    res = alu_ref(f3, f3 == 3'b101 && inst[30], a,
                        {{20{inst[31]}}, inst[31:20]});
                    wr = 1'b1;
                end
                7'b0110011: begin
                    // other funct7 values are outside RV32I
                    if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
                        res = alu_ref(f3, inst[30], a, b);
                        wr = 1'b1;
                    end
                end
                7'b0110111: begin
                    res = {inst[31:12], 12'h000};
                    wr = 1'b1;
                end
                7'b0010111: begin
                    res = pc + {inst[31:12], 12'h000};
                    wr = 1'b1;
                end
                7'b1101111: begin
                    res = pc + 32'd4;
                    wr = 1'b1;
                    next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                        inst[30:21], 1'b0};
                end
                7'b1100011: begin
                    if (branch_taken(f3, a, b)) begin
                        next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
                    end
                end
                7'b0100011: queue_store(a + {{20{inst[31]}}, inst[31:25], inst[11:7]}, f3, b);
                default: begin
                    // loads and system ops retire as no-ops
                end
            endcase
            if (wr && rd != 5'd0) begin
                x[rd] = res;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    // answers one cycle after the request, with gaps and waits
    always @(posedge clk) begin
        if (rst) begin
            inst_rvalid <= 1'b0;
            mem_wait <= 1'b0;
        end else begin
            rng = xorshift(rng);
            inst_rvalid <= inst_rden && rng[2:0] != 3'b000;
            mem_wait <= rng[2:0] != 3'b000 && rng[5:3] == 3'b000;
            inst_roaddr <= inst_riaddr;
            inst_rdata <= fetch_word(inst_riaddr);
        end
    end

    always @(posedge clk) begin
        if (!rst && data_wren === 1'b1 && mem_wait === 1'b0) begin
            if (exp_addr.size() == 0) begin
                stop_with_error($sformatf("unexpected store to %h after %0d expected stores",
                    data_waddr, stores_seen));
            end else begin
                addr_compare("data_waddr", data_waddr, exp_addr.pop_front());
                strb_compare(data_wstrb, exp_strb[0]);
                data_compare(data_wdata, exp_data.pop_front(), exp_strb.pop_front());
                stores_seen++;
            end
        end
    end

    // only the final self-jump pulls the fetch address back onto the last word
    always @(posedge clk) begin
        if (rst) begin
            last_fetch <= start_addr;
        end else begin
            if (inst_rden && last_fetch > final_addr && inst_riaddr == final_addr) begin
                reached_end <= 1'b1;
            end
            last_fetch <= inst_riaddr;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inst_roaddr = '0;
        inst_rvalid = 1'b0;
        inst_rdata = '0;
        mem_wait = 1'b0;
        reached_end = 1'b0;
        stores_seen = 0;
        rng = 32'hc2a5_ea2e;
        build_program();
        run_model();
        $display("program of %0d words, %0d stores expected", prog_words, exp_addr.size());
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        while (inst_rden !== 1'b1) begin
            if (data_wren !== 1'b0) begin
                stop_with_error("store port active right after reset");
            end
            @(posedge clk);
        end
        addr_compare("inst_riaddr", inst_riaddr, start_addr);
        wait (reached_end);
        if (exp_addr.size() == 0) begin
            $display("%0d stores checked", stores_seen);
            $display("Testbench passed");
            $finish;
        end else begin
            stop_with_error($sformatf("core reached its final jump with %0d stores missing",
                exp_addr.size()));
        end
    end

    initial begin
        #(timeout_ns);
        stop_with_error($sformatf("timeout after %0d ns without reaching the final jump",
            timeout_ns));
    end

endmodule

`default_nettype wire
